// ==== all.f ====
hdl/stcBusPkg.sv
hdl/stcSignalPkg.sv
hdl/regBusIf.sv
hdl/busRegs.sv
hdl/adcFrontEnd.sv
hdl/dacChannel.sv
hdl/demodBoardTop.sv
dv/demodBoardTb.sv

// ==== dv/demodBoardTb.sv ====
`default_nettype none

module demodBoardTb
    import stcBusPkg::*;
    import stcSignalPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int MAX_ENTRIES = 96;

    // Port selectors for opPort entries
    localparam int PORT_CLOCKS_PER_BIT = 0;
    localparam int PORT_PILOT_OFFSET   = 1;
    localparam int PORT_SPECTRUM_INV   = 2;
    localparam int PORT_STC_DAC_SELECT = 3;
    localparam int PORT_VIDEO0_IN      = 4;
    localparam int PORT_VIDEO0_OUT     = 5;
    localparam int PORT_VIDEO1_IN      = 6;
    localparam int PORT_VIDEO1_OUT     = 7;
    localparam int PORT_DAC0           = 8;
    localparam int PORT_DAC1           = 9;
    localparam int PORT_DATA_OUT       = 10;
    localparam int PORT_LED0           = 11;
    localparam int PORT_LED1           = 12;

    typedef enum logic [2:0] {
        opWrite, opRead, opAdc, opDac0, opDac1, opPort, opClk
    } opKind_e;

    logic clk, reset, cs, rd, adcOverflow;
    logic [3:0] byteWrite;
    busAddr_t addr;
    busData_t dataIn, dataOut;
    logic [13:0] adc, dac0Data, dac1Data;
    sample_t adcSample, demodDac0Data, demodDac1Data, stcDac0Data, stcDac1Data;
    logic demodDac0En, demodDac1En, stcDac0En, stcDac1En;
    logic pilotFound, pilotLocked, dac0Clk, dac1Clk, spectrumInvert, lockLed0n, lockLed1n;
    logic [15:0] clocksPerBit;
    logic [11:0] pilotOffset;
    logic [3:0] stcDacSelect;
    videoSel_t video0InSelect, video0OutSelect, video1InSelect, video1OutSelect;

    // Stimulus table
    opKind_e     opTable   [MAX_ENTRIES];
    logic [31:0] argTable  [MAX_ENTRIES];  // Address, ADC code or demod sample
    logic [3:0]  laneTable [MAX_ENTRIES];  // Byte lanes, overflow or enables
    logic [31:0] dataTable [MAX_ENTRIES];  // Write data or STC sample
    logic [31:0] expTable  [MAX_ENTRIES];
    string       nameTable [MAX_ENTRIES];

    int     numEntries;
    int     errorCount;
    int     failedEntries;
    bit     tableReady;
    integer seed;

    demodBoardTop u_demodBoardTop (
        .clk(clk), .reset(reset), .cs(cs), .rd(rd), .byteWrite(byteWrite), .addr(addr),
        .dataIn(dataIn), .dataOut(dataOut), .adc(adc), .adcOverflow(adcOverflow),
        .adcSample(adcSample), .demodDac0Data(demodDac0Data), .demodDac1Data(demodDac1Data),
        .stcDac0Data(stcDac0Data), .stcDac1Data(stcDac1Data), .demodDac0En(demodDac0En),
        .demodDac1En(demodDac1En), .stcDac0En(stcDac0En), .stcDac1En(stcDac1En),
        .pilotFound(pilotFound), .pilotLocked(pilotLocked), .dac0Data(dac0Data),
        .dac1Data(dac1Data), .dac0Clk(dac0Clk), .dac1Clk(dac1Clk),
        .clocksPerBit(clocksPerBit), .pilotOffset(pilotOffset),
        .spectrumInvert(spectrumInvert), .stcDacSelect(stcDacSelect),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect),
        .lockLed0n(lockLed0n), .lockLed1n(lockLed1n)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //**************************************************
    // Reference model
    //**************************************************
    function automatic logic [31:0] regAddr(input int space, input int index);
        return (space << SPACE_SHIFT) + index;
    endfunction

    // Offset binary minus midscale, times 16 for the pad bits
    function automatic logic [31:0] adcExpected(input logic [13:0] code);
        int value;
        value = code;
        return (value - 8192) * 16;
    endfunction

    // Top 14 bits of the sample, shifted to offset binary
    function automatic logic [31:0] dacExpected(input logic [17:0] sample);
        int value;
        value = $signed(sample);
        return ((value >>> 4) + 8192) & 32'h3fff;
    endfunction

    function automatic logic [31:0] mappedOutSelect(input int sel);
        if (sel == 1) return 2;
        if (sel == 2) return 1;
        return sel;
    endfunction

    function automatic logic [31:0] portValue(input int which);
        case (which)
            PORT_CLOCKS_PER_BIT: return clocksPerBit;
            PORT_PILOT_OFFSET:   return pilotOffset;
            PORT_SPECTRUM_INV:   return spectrumInvert;
            PORT_STC_DAC_SELECT: return stcDacSelect;
            PORT_VIDEO0_IN:      return video0InSelect;
            PORT_VIDEO0_OUT:     return video0OutSelect;
            PORT_VIDEO1_IN:      return video1InSelect;
            PORT_VIDEO1_OUT:     return video1OutSelect;
            PORT_DAC0:           return dac0Data;
            PORT_DAC1:           return dac1Data;
            PORT_DATA_OUT:       return dataOut;
            PORT_LED0:           return lockLed0n;
            default:             return lockLed1n;
        endcase
    endfunction

    function automatic string portName(input int which);
        case (which)
            PORT_CLOCKS_PER_BIT: return "clocksPerBit";
            PORT_PILOT_OFFSET:   return "pilotOffset";
            PORT_SPECTRUM_INV:   return "spectrumInvert";
            PORT_STC_DAC_SELECT: return "stcDacSelect";
            PORT_VIDEO0_IN:      return "video0InSelect";
            PORT_VIDEO0_OUT:     return "video0OutSelect";
            PORT_VIDEO1_IN:      return "video1InSelect";
            PORT_VIDEO1_OUT:     return "video1OutSelect";
            PORT_DAC0:           return "dac0Data";
            PORT_DAC1:           return "dac1Data";
            PORT_DATA_OUT:       return "dataOut";
            PORT_LED0:           return "lockLed0n";
            default:             return "lockLed1n";
        endcase
    endfunction

    function automatic logic [17:0] nextSample();
        return $random(seed);
    endfunction

    //**************************************************
    // Table construction
    //**************************************************
    task automatic addEntry(input opKind_e op, input logic [31:0] arg, input logic [3:0] lanes,
                            input logic [31:0] data, input logic [31:0] expValue,
                            input string name);
        opTable[numEntries]   = op;
        argTable[numEntries]  = arg;
        laneTable[numEntries] = lanes;
        dataTable[numEntries] = data;
        expTable[numEntries]  = expValue;
        nameTable[numEntries] = name;
        numEntries++;
    endtask

    task automatic buildTable();
        int          p;
        int          v;
        logic [13:0] code;
        logic [17:0] demodSample;
        logic [17:0] stcSample;
        logic [31:0] held;
        logic [31:0] ctrlWord;
        numEntries = 0;
        // Reset values
        addEntry(opPort, PORT_DATA_OUT, 0, 0, 0, "dataOut after reset");
        for (p = PORT_CLOCKS_PER_BIT; p <= PORT_VIDEO1_OUT; p++) begin
            addEntry(opPort, p, 0, 0, 0, {portName(p), " after reset"});
        end
        addEntry(opPort, PORT_DAC0, 0, 0, 8192, "dac0Data midscale");
        addEntry(opPort, PORT_DAC1, 0, 0, 8192, "dac1Data midscale");
        addEntry(opPort, PORT_LED0, 0, 0, 1, "lockLed0n follows pilotFound");
        addEntry(opPort, PORT_LED1, 0, 0, 0, "lockLed1n follows pilotLocked");
        // DAC clocks low then high within one clock period
        addEntry(opClk, 0, 0, 0, 32'b10, "dac0Clk follows clk");
        addEntry(opClk, 1, 0, 0, 32'b10, "dac1Clk follows clk");
        addEntry(opRead, regAddr(TOP_SPACE, REG_VERSION), 0, 0, 530, "version read");
        addEntry(opRead, 32'h035, 0, 0, 0, "unmapped read");
        addEntry(opRead, regAddr(ADC_SPACE, REG_ADC_STATUS), 0, 0, 0, "overflow after reset");

        // Byte lanes, full then lane 1 only
        addEntry(opWrite, regAddr(STC_SPACE, REG_CLOCKS_PER_BIT), 4'hf, 32'h0000_a5c3, 0,
                 "clocksPerBit full write");
        addEntry(opRead, regAddr(STC_SPACE, REG_CLOCKS_PER_BIT), 0, 0, 32'h0000_a5c3,
                 "clocksPerBit readback");
        addEntry(opWrite, regAddr(STC_SPACE, REG_PILOT), 4'hf, 32'h00a1_0b7e, 0,
                 "pilot full write");
        addEntry(opRead, regAddr(STC_SPACE, REG_PILOT), 0, 0, 32'h00a1_0b7e, "pilot readback");
        addEntry(opWrite, regAddr(STC_SPACE, REG_CLOCKS_PER_BIT), 4'b0010, 32'hffff_5aff, 0,
                 "clocksPerBit lane 1 write");
        addEntry(opRead, regAddr(STC_SPACE, REG_CLOCKS_PER_BIT), 0, 0, 32'h0000_5ac3,
                 "clocksPerBit lane 1 readback");
        addEntry(opWrite, regAddr(STC_SPACE, REG_PILOT), 4'b0010, 32'h0000_0300, 0,
                 "pilot lane 1 write");
        addEntry(opRead, regAddr(STC_SPACE, REG_PILOT), 0, 0, 32'h00a1_037e,
                 "pilot lane 1 readback");
        addEntry(opPort, PORT_CLOCKS_PER_BIT, 0, 0, 32'h5ac3, "clocksPerBit port");
        addEntry(opPort, PORT_PILOT_OFFSET, 0, 0, 32'h37e, "pilotOffset port");
        addEntry(opPort, PORT_SPECTRUM_INV, 0, 0, 1, "spectrumInvert port");
        addEntry(opPort, PORT_STC_DAC_SELECT, 0, 0, 32'ha, "stcDacSelect port");

        // Video select mapping, channel 1 runs the values backwards
        for (v = 0; v < 4; v++) begin
            ctrlWord = (v << 8) | ((3 - v) << 10);
            addEntry(opWrite, regAddr(TOP_SPACE, REG_CONTROL), 4'b0010, ctrlWord, 0,
                     $sformatf("video select %0d write", v));
            addEntry(opRead, regAddr(TOP_SPACE, REG_CONTROL), 0, 0, ctrlWord,
                     $sformatf("video select %0d readback", v));
            addEntry(opPort, PORT_VIDEO0_IN, 0, 0, v, $sformatf("video0InSelect %0d", v));
            addEntry(opPort, PORT_VIDEO0_OUT, 0, 0, mappedOutSelect(v),
                     $sformatf("video0OutSelect %0d", v));
            addEntry(opPort, PORT_VIDEO1_IN, 0, 0, 3 - v, $sformatf("video1InSelect %0d", 3 - v));
            addEntry(opPort, PORT_VIDEO1_OUT, 0, 0, mappedOutSelect(3 - v),
                     $sformatf("video1OutSelect %0d", 3 - v));
        end

        //**************************************************
        // ADC conversion and sticky overflow
        //**************************************************
        for (v = 0; v < 5; v++) begin
            code = $random(seed);
            addEntry(opAdc, code, (v == 4), 0, adcExpected(code),
                     $sformatf("adc code %h%s", code, (v == 4) ? " with overflow" : ""));
        end
        addEntry(opRead, regAddr(ADC_SPACE, REG_ADC_STATUS), 0, 0, 1, "overflow flag set");
        addEntry(opWrite, regAddr(ADC_SPACE, REG_ADC_STATUS), 4'b0001, 1, 0, "overflow clear");
        addEntry(opRead, regAddr(ADC_SPACE, REG_ADC_STATUS), 0, 0, 0, "overflow flag cleared");

        // DAC0 takes stc, DAC1 has illegal code 5 and falls back to demod
        addEntry(opWrite, regAddr(TOP_SPACE, REG_CONTROL), 4'b0011, 32'h0000_0051, 0,
                 "dac sources write");
        held = 8192;
        for (v = 0; v < 4; v++) begin
            demodSample = nextSample();
            stcSample   = nextSample();
            if (v == 0 || v == 3) held = dacExpected(stcSample);
            addEntry(opDac0, demodSample, (v == 0) ? 4'b0010 : (v == 1) ? 4'b0001 :
                     (v == 2) ? 4'b0000 : 4'b0011, stcSample, held,
                     $sformatf("dac0 step %0d", v));
        end
        held = 8192;
        for (v = 0; v < 4; v++) begin
            demodSample = nextSample();
            stcSample   = nextSample();
            if (v == 0 || v == 3) held = dacExpected(demodSample);
            addEntry(opDac1, demodSample, (v == 0) ? 4'b0001 : (v == 1) ? 4'b0010 :
                     (v == 2) ? 4'b0000 : 4'b0011, stcSample, held,
                     $sformatf("dac1 step %0d", v));
        end
    endtask

    //**************************************************
    // Entry execution
    //**************************************************
    task automatic reportMismatch(input string signalName, input logic [31:0] expValue,
                                  input logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, signalName, expValue,
                 actual);
        errorCount++;
    endtask

    task automatic runEntry(input int idx);
        logic [31:0] actual;
        int          adcValue;
        bit          entryOk;
        entryOk = 1'b1;
        case (opTable[idx])
            opWrite, opRead: begin
                cs        = 1'b1;
                rd        = (opTable[idx] == opRead);
                byteWrite = (opTable[idx] == opWrite) ? laneTable[idx] : 4'b0000;
                addr      = argTable[idx][BUS_ADDR_WIDTH-1:0];
                dataIn    = dataTable[idx];
                @(negedge clk);
                cs        = 1'b0;
                rd        = 1'b0;
                byteWrite = 4'b0000;
                if (opTable[idx] == opRead && dataOut !== expTable[idx]) begin
                    reportMismatch("dataOut", expTable[idx], dataOut);
                    entryOk = 1'b0;
                end
            end
            opAdc: begin
                adc         = argTable[idx][13:0];
                adcOverflow = laneTable[idx][0];
                @(negedge clk);
                adcOverflow = 1'b0;     // Single cycle pulse
                @(negedge clk);
                adcValue = adcSample;
                actual   = adcValue;
                if (actual !== expTable[idx]) begin
                    reportMismatch("adcSample", expTable[idx], actual);
                    entryOk = 1'b0;
                end
            end
            opDac0, opDac1: begin
                if (opTable[idx] == opDac0) begin
                    demodDac0Data = argTable[idx][17:0];
                    stcDac0Data   = dataTable[idx][17:0];
                    demodDac0En   = laneTable[idx][0];
                    stcDac0En     = laneTable[idx][1];
                end else begin
                    demodDac1Data = argTable[idx][17:0];
                    stcDac1Data   = dataTable[idx][17:0];
                    demodDac1En   = laneTable[idx][0];
                    stcDac1En     = laneTable[idx][1];
                end
                @(negedge clk);
                {demodDac0En, stcDac0En, demodDac1En, stcDac1En} = 4'b0000;
                repeat (2) @(negedge clk);
                actual = (opTable[idx] == opDac0) ? dac0Data : dac1Data;
                if (actual !== expTable[idx]) begin
                    reportMismatch((opTable[idx] == opDac0) ? "dac0Data" : "dac1Data",
                                   expTable[idx], actual);
                    entryOk = 1'b0;
                end
            end
            opClk: begin
                actual = '0;
                #1;
                actual[0] = (argTable[idx] == 0) ? dac0Clk : dac1Clk;    // Low phase
                #(CLK_PERIOD / 2);
                actual[1] = (argTable[idx] == 0) ? dac0Clk : dac1Clk;    // High phase
                if (actual !== expTable[idx]) begin
                    reportMismatch((argTable[idx] == 0) ? "dac0Clk" : "dac1Clk",
                                   expTable[idx], actual);
                    entryOk = 1'b0;
                end
                @(negedge clk);
            end
            default: begin
                actual = portValue(argTable[idx]);
                if (actual !== expTable[idx]) begin
                    reportMismatch(portName(argTable[idx]), expTable[idx], actual);
                    entryOk = 1'b0;
                end
            end
        endcase
        if (!entryOk) failedEntries++;
        $display("%0t ns: %s %s", $time, nameTable[idx], entryOk ? "ok" : "FAILED");
    endtask

    //**************************************************
    // Main sequence and watchdog
    //**************************************************
    initial begin : stimulus
        int idx;
        reset = 1'b1;
        {cs, rd, adcOverflow} = 3'b000;
        byteWrite = 4'b0000;
        addr      = '0;
        dataIn    = '0;
        adc       = 14'h2000;
        {demodDac0Data, demodDac1Data, stcDac0Data, stcDac1Data} = '0;
        {demodDac0En, demodDac1En, stcDac0En, stcDac1En} = 4'b0000;
        pilotFound  = 1'b1;     // LEDs held at fixed levels
        pilotLocked = 1'b0;
        seed          = 36;
        errorCount    = 0;
        failedEntries = 0;
        buildTable();
        tableReady = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (idx = 0; idx < numEntries; idx++) begin
            runEntry(idx);
        end
        $display("Entries: %0d, failed entries: %0d, errors: %0d", numEntries, failedEntries,
                 errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        wait (tableReady);
        #(numEntries * 8 * CLK_PERIOD + 100);
        $display("Timeout: the stimulus table did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/adcFrontEnd.sv ====
`default_nettype none

module adcFrontEnd
    import stcBusPkg::*;
    import stcSignalPkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire [ADC_WIDTH-1:0]  adc,
    input  wire                  adcOverflow,
    output sample_t              adcSample,
    regBusIf.blk                 regBus
);

    logic [ADC_WIDTH-1:0] adcReg;
    logic                 overflowReg;
    logic                 overflowFlag;
    logic                 clearWrite;

    //**************************************************
    // Reclock and format conversion
    //**************************************************
    always_ff @(posedge clk) begin
        adcReg    <= adc;
        // Offset binary to two's complement, scaled up to sample width
        adcSample <= $signed({~adcReg[ADC_WIDTH-1], adcReg[ADC_WIDTH-2:0],
                              {ADC_PAD_BITS{1'b0}}});
    end

    //**************************************************
    // Sticky overflow status
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            overflowReg <= 1'b0;
        end else begin
            overflowReg <= adcOverflow;
        end
    end

    // Write a one to bit 0 to clear
    assign clearWrite = regBus.sel && regBus.wrLanes[0]
                        && (regBus.wordIndex == REG_ADC_STATUS) && regBus.wrData[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            overflowFlag <= 1'b0;
        end else if (clearWrite) begin
            overflowFlag <= 1'b0;               // Clear beats a new overflow
        end else if (overflowReg) begin
            overflowFlag <= 1'b1;
        end
    end

    assign regBus.rdData = (regBus.wordIndex == REG_ADC_STATUS)
                           ? {{(BUS_DATA_WIDTH-1){1'b0}}, overflowFlag}
                           : '0;

endmodule

`default_nettype wire

// ==== hdl/busRegs.sv ====
`default_nettype none

module busRegs
    import stcBusPkg::*;
    import stcSignalPkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cs,
    input  wire                   rd,
    input  wire [BYTE_LANES-1:0]  byteWrite,
    input  wire busAddr_t         addr,
    input  wire busData_t         dataIn,
    output busData_t              dataOut,
    output dacSource_e            dac0Source,
    output dacSource_e            dac1Source,
    output logic [15:0]           clocksPerBit,
    output logic [11:0]           pilotOffset,
    output logic                  spectrumInvert,
    output logic [3:0]            stcDacSelect,
    output videoSel_t             video0InSelect,
    output videoSel_t             video0OutSelect,
    output videoSel_t             video1InSelect,
    output videoSel_t             video1OutSelect,
    regBusIf.ctrl                 regBus
);

    logic [BUS_ADDR_WIDTH-SPACE_SHIFT-1:0] space;
    logic [SPACE_SHIFT-1:0]                wordIndex;
    logic                                  busWrite;
    logic                                  topWrite;
    logic                                  stcWrite;

    busData_t controlReg;
    busData_t clocksPerBitReg;
    busData_t pilotReg;
    busData_t readMux;

    // Merge the enabled byte lanes of data into current
    function automatic busData_t laneWrite(input busData_t current, input busData_t data,
                                           input logic [BYTE_LANES-1:0] lanes);
        busData_t merged;
        merged = current;
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (lanes[lane]) begin
                merged[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    // Board routes select lines 1 and 2 crossed
    function automatic videoSel_t swapVideo(input videoSel_t sel);
        case (sel)
            2'd1:    return 2'd2;
            2'd2:    return 2'd1;
            default: return sel;
        endcase
    endfunction

    //**************************************************
    // Address decode
    //**************************************************
    assign space     = addr[BUS_ADDR_WIDTH-1:SPACE_SHIFT];
    assign wordIndex = addr[SPACE_SHIFT-1:0];
    assign busWrite  = cs && (|byteWrite);
    assign topWrite  = busWrite && (space == TOP_SPACE);
    assign stcWrite  = busWrite && (space == STC_SPACE);

    // ADC block gets its own select, lanes gated by cs
    assign regBus.sel       = cs && (space == ADC_SPACE);
    assign regBus.wrLanes   = cs ? byteWrite : '0;
    assign regBus.wordIndex = wordIndex;
    assign regBus.wrData    = dataIn;

    //**************************************************
    // Configuration registers
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            controlReg      <= '0;
            clocksPerBitReg <= '0;
            pilotReg        <= '0;
        end else begin
            if (topWrite && wordIndex == REG_CONTROL) begin
                controlReg <= laneWrite(controlReg, dataIn, byteWrite) & CONTROL_MASK;
            end
            if (stcWrite && wordIndex == REG_CLOCKS_PER_BIT) begin
                clocksPerBitReg <= laneWrite(clocksPerBitReg, dataIn, byteWrite)
                                   & CLOCKS_PER_BIT_MASK;
            end
            if (stcWrite && wordIndex == REG_PILOT) begin
                pilotReg <= laneWrite(pilotReg, dataIn, byteWrite) & PILOT_MASK;
            end
        end
    end

    assign dac0Source = dacSource_e'(controlReg[3:0]);
    assign dac1Source = dacSource_e'(controlReg[7:4]);

    assign video0InSelect  = controlReg[9:8];
    assign video1InSelect  = controlReg[11:10];
    assign video0OutSelect = swapVideo(controlReg[9:8]);
    assign video1OutSelect = swapVideo(controlReg[11:10]);

    // STC core settings
    assign clocksPerBit   = clocksPerBitReg[15:0];
    assign pilotOffset    = pilotReg[11:0];
    assign spectrumInvert = pilotReg[16];
    assign stcDacSelect   = pilotReg[23:20];

    //**************************************************
    // Read data mux
    //**************************************************
    always_comb begin
        readMux = '0;   // Unmapped words read zero
        case (space)
            TOP_SPACE: begin
                case (wordIndex)
                    REG_VERSION: readMux = VERSION_NUMBER;
                    REG_CONTROL: readMux = controlReg;
                    default:     readMux = '0;
                endcase
            end
            STC_SPACE: begin
                case (wordIndex)
                    REG_CLOCKS_PER_BIT: readMux = clocksPerBitReg;
                    REG_PILOT:          readMux = pilotReg;
                    default:            readMux = '0;
                endcase
            end
            ADC_SPACE: readMux = regBus.rdData;
            default:   readMux = '0;
        endcase
    end

    // One cycle read latency, held until the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            dataOut <= '0;
        end else if (cs && rd) begin
            dataOut <= readMux;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dacChannel.sv ====
`default_nettype none

module dacChannel
    import stcSignalPkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire dacSource_e        source,
    input  wire sample_t           demodData,
    input  wire sample_t           stcData,
    input  wire                    demodEn,
    input  wire                    stcEn,
    output logic [DAC_WIDTH-1:0]   dacData
);

    sample_t selData;
    logic    selEn;
    sample_t chosenData;
    logic    chosenEn;
    sample_t holdData;

    //**************************************************
    // Source select
    //**************************************************
    always_comb begin
        case (source)
            dacSrcStc: begin
                selData = stcData;
                selEn   = stcEn;
            end
            default: begin
                selData = demodData;            // Demod for any other code
                selEn   = demodEn;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        chosenData <= selData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chosenEn <= 1'b0;
        end else begin
            chosenEn <= selEn;
        end
    end

    // Zero order hold between enables
    always_ff @(posedge clk) begin
        if (reset) begin
            holdData <= '0;
        end else if (chosenEn) begin
            holdData <= chosenData;
        end
    end

    //**************************************************
    // Offset binary output
    //**************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            dacData <= {1'b1, {(DAC_WIDTH-1){1'b0}}};   // Midscale
        end else begin
            dacData <= {~holdData[SAMPLE_WIDTH-1],
                        holdData[SAMPLE_WIDTH-2:SAMPLE_WIDTH-DAC_WIDTH]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/demodBoardTop.sv ====
`default_nettype none

module demodBoardTop
    import stcBusPkg::*;
    import stcSignalPkg::*;
(
    input  wire                   clk,
    input  wire                   reset,

    // Register bus
    input  wire                   cs,
    input  wire                   rd,
    input  wire [BYTE_LANES-1:0]  byteWrite,
    input  wire busAddr_t         addr,
    input  wire busData_t         dataIn,
    output busData_t              dataOut,

    // ADC
    input  wire [ADC_WIDTH-1:0]   adc,
    input  wire                   adcOverflow,
    output sample_t               adcSample,

    // Sample streams from the cores
    input  wire sample_t          demodDac0Data,
    input  wire sample_t          demodDac1Data,
    input  wire sample_t          stcDac0Data,
    input  wire sample_t          stcDac1Data,
    input  wire                   demodDac0En,
    input  wire                   demodDac1En,
    input  wire                   stcDac0En,
    input  wire                   stcDac1En,
    input  wire                   pilotFound,
    input  wire                   pilotLocked,

    // DACs
    output logic [DAC_WIDTH-1:0]  dac0Data,
    output logic [DAC_WIDTH-1:0]  dac1Data,
    output logic                  dac0Clk,
    output logic                  dac1Clk,

    // STC core settings
    output logic [15:0]           clocksPerBit,
    output logic [11:0]           pilotOffset,
    output logic                  spectrumInvert,
    output logic [3:0]            stcDacSelect,

    // Video switch and LEDs
    output videoSel_t             video0InSelect,
    output videoSel_t             video0OutSelect,
    output videoSel_t             video1InSelect,
    output videoSel_t             video1OutSelect,
    output logic                  lockLed0n,
    output logic                  lockLed1n
);

    dacSource_e dac0Source;
    dacSource_e dac1Source;

    regBusIf regBus ();

    //**************************************************
    // Control
    //**************************************************
    busRegs u_busRegs (
        .clk             (clk),
        .reset           (reset),
        .cs              (cs),
        .rd              (rd),
        .byteWrite       (byteWrite),
        .addr            (addr),
        .dataIn          (dataIn),
        .dataOut         (dataOut),
        .dac0Source      (dac0Source),
        .dac1Source      (dac1Source),
        .clocksPerBit    (clocksPerBit),
        .pilotOffset     (pilotOffset),
        .spectrumInvert  (spectrumInvert),
        .stcDacSelect    (stcDacSelect),
        .video0InSelect  (video0InSelect),
        .video0OutSelect (video0OutSelect),
        .video1InSelect  (video1InSelect),
        .video1OutSelect (video1OutSelect),
        .regBus          (regBus.ctrl)
    );

    //**************************************************
    // Datapath
    //**************************************************
    adcFrontEnd u_adcFrontEnd (
        .clk         (clk),
        .reset       (reset),
        .adc         (adc),
        .adcOverflow (adcOverflow),
        .adcSample   (adcSample),
        .regBus      (regBus.blk)
    );

    dacChannel u_dac0 (
        .clk       (clk),
        .reset     (reset),
        .source    (dac0Source),
        .demodData (demodDac0Data),
        .stcData   (stcDac0Data),
        .demodEn   (demodDac0En),
        .stcEn     (stcDac0En),
        .dacData   (dac0Data)
    );

    dacChannel u_dac1 (
        .clk       (clk),
        .reset     (reset),
        .source    (dac1Source),
        .demodData (demodDac1Data),
        .stcData   (stcDac1Data),
        .demodEn   (demodDac1En),
        .stcEn     (stcDac1En),
        .dacData   (dac1Data)
    );

    assign dac0Clk = clk;       // DACs run on the system clock
    assign dac1Clk = clk;

    assign lockLed0n = pilotFound;
    assign lockLed1n = pilotLocked;

endmodule

`default_nettype wire

// ==== hdl/regBusIf.sv ====
`default_nettype none

interface regBusIf
    import stcBusPkg::*;
();

    logic                    sel;           // ADC space hit
    logic [BYTE_LANES-1:0]   wrLanes;
    logic [SPACE_SHIFT-1:0]  wordIndex;
    busData_t                wrData;
    busData_t                rdData;

    // Decoder side
    modport ctrl (
        output sel, wrLanes, wordIndex, wrData,
        input  rdData
    );

    // Register block side
    modport blk (
        input  sel, wrLanes, wordIndex, wrData,
        output rdData
    );

endinterface

`default_nettype wire

// ==== hdl/stcBusPkg.sv ====
`default_nettype none

package stcBusPkg;

    // Bus geometry
    localparam int BUS_ADDR_WIDTH = 13;
    localparam int BUS_DATA_WIDTH = 32;
    localparam int BYTE_LANES     = 4;
    localparam int SPACE_SHIFT    = 4;      // Word index below, space number above

    typedef logic [BUS_ADDR_WIDTH-1:0] busAddr_t;
    typedef logic [BUS_DATA_WIDTH-1:0] busData_t;

    // Address spaces
    localparam int TOP_SPACE = 0;
    localparam int STC_SPACE = 1;
    localparam int ADC_SPACE = 2;

    // Word indices, top space
    localparam int REG_VERSION = 0;
    localparam int REG_CONTROL = 1;

    // Word indices, STC space
    localparam int REG_CLOCKS_PER_BIT = 0;
    localparam int REG_PILOT          = 1;

    // Word indices, ADC space
    localparam int REG_ADC_STATUS = 0;

    // Implemented bits of each writable word
    localparam busData_t CONTROL_MASK        = 32'h0000_0fff;
    localparam busData_t CLOCKS_PER_BIT_MASK = 32'h0000_ffff;
    localparam busData_t PILOT_MASK          = 32'h00f1_0fff;

    localparam busData_t VERSION_NUMBER = 32'd530;

endpackage

`default_nettype wire

// ==== hdl/stcSignalPkg.sv ====
`default_nettype none

package stcSignalPkg;

    // Sample widths
    localparam int ADC_WIDTH    = 14;
    localparam int SAMPLE_WIDTH = 18;
    localparam int DAC_WIDTH    = 14;
    localparam int ADC_PAD_BITS = 4;        // Zeros below the ADC code

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // DAC source select, unknown codes fall back to the demod
    typedef enum logic [3:0] {
        dacSrcDemod = 4'd0,
        dacSrcStc   = 4'd1
    } dacSource_e;

    // Video switch select lines
    typedef logic [1:0] videoSel_t;

endpackage

`default_nettype wire
